// ==== rtl/dbgPkg.sv ====
`default_nettype none

package dbgPkg;

    // ==============================
    // Widths
    // ==============================

    // One byte on the serial link
    typedef logic [7:0] byte_t;

    // Scratch memory word address and word
    typedef logic [7:0] memAddr_t;
    typedef logic [15:0] memData_t;

    // ==============================
    // Message types
    // ==============================

    // Type byte of a message, zero is a filler that the receiver skips
    typedef enum logic [7:0] {
        MsgNop      = 8'h00,
        MsgSetLed   = 8'h01,
        MsgFillMem  = 8'h02,
        MsgReadMem  = 8'h03,
        MsgReadResp = 8'h83
    } msgType_t;

    // Payload bytes kept per message, extra ones are counted and dropped
    localparam int MsgMaxPayloadLen = 5;

    // Output byte queue depth, also the initial byte credit count
    localparam int OutQueueDepth = 8;

endpackage

`default_nettype wire

// ==== rtl/dbgIfc.sv ====
`default_nettype none

// One framed message, valid for one cycle, credit returned on consumption
interface msgIfc #(
    parameter int MsgMaxPayloadLen = dbgPkg::MsgMaxPayloadLen
);
    logic valid;
    dbgPkg::byte_t msgType;
    dbgPkg::byte_t payloadLen;
    dbgPkg::byte_t [MsgMaxPayloadLen-1:0] payload;
    logic credit;

    modport sender (output valid, msgType, payloadLen, payload, input credit);
    modport receiver (input valid, msgType, payloadLen, payload, output credit);
endinterface

// Byte stream into the output queue, one credit per queue slot
interface byteIfc #(
    parameter int OutQueueDepth = dbgPkg::OutQueueDepth
);
    logic valid;
    dbgPkg::byte_t data;
    logic credit;

    modport sender (output valid, data, input credit);
    modport receiver (input valid, data, output credit);
endinterface

// Scratch memory port, req held until gnt, read data one cycle after gnt
interface memIfc;
    logic req;
    logic write;
    dbgPkg::memAddr_t addr;
    dbgPkg::memData_t wdata;
    logic gnt;
    logic rdataValid;
    dbgPkg::memData_t rdata;

    modport requester (
        output req, write, addr, wdata,
        input gnt, rdataValid, rdata
    );
    modport responder (
        input req, write, addr, wdata,
        output gnt, rdataValid, rdata
    );
endinterface

`default_nettype wire

// ==== rtl/serialLink.sv ====
`default_nettype none

module serialLink #(
    parameter int MsgMaxPayloadLen = dbgPkg::MsgMaxPayloadLen,
    parameter int OutQueueDepth = dbgPkg::OutQueueDepth
) (
    input wire clk,
    input wire rstN,
    input wire debugClk,
    input wire debugCs,
    input wire debugDi,
    output logic debugDo,
    msgIfc.sender rxMsg,
    byteIfc.receiver txByte
);
    localparam int IdxW = (MsgMaxPayloadLen > 1) ? $clog2(MsgMaxPayloadLen) : 1;
    localparam int PtrW = (OutQueueDepth > 1) ? $clog2(OutQueueDepth) : 1;
    localparam int CntW = $clog2(OutQueueDepth + 1);

    typedef enum logic [1:0] {RxType, RxLen, RxPayload} rxState_t;

    logic [2:0] clkQ;
    logic [1:0] csQ;
    logic [1:0] diQ;
    logic clkRise;
    logic csOn;

    logic [2:0] bitCnt;
    logic byteDone;
    dbgPkg::byte_t shiftIn;

    rxState_t rxState;
    dbgPkg::byte_t payloadCnt;
    logic canSend;
    logic msgValid;
    logic frameDone;
    dbgPkg::byte_t msgType;
    dbgPkg::byte_t payloadLen;
    dbgPkg::byte_t [MsgMaxPayloadLen-1:0] payload;

    dbgPkg::byte_t queue [OutQueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] qCount;
    logic popByte;
    logic txCredit;
    logic [2:0] slotCnt;
    dbgPkg::byte_t shiftOut;

    // ==============================
    // Synchroniser
    // ==============================

    // Clock, select and data go through the same depth so they stay aligned
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            clkQ <= '0;
            csQ <= '0;
            diQ <= '0;
        end else begin
            clkQ <= {clkQ[1:0], debugClk};
            csQ <= {csQ[0], debugCs};
            diQ <= {diQ[0], debugDi};
        end
    end

    assign clkRise = clkQ[1] & ~clkQ[2];
    assign csOn = csQ[1];

    // ==============================
    // Deserialiser and framing
    // ==============================

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bitCnt <= '0;
            byteDone <= 1'b0;
        end else begin
            byteDone <= 1'b0;
            if (!csOn) begin
                bitCnt <= '0;
            end else if (clkRise) begin
                bitCnt <= bitCnt + 3'd1;
                byteDone <= (bitCnt == 3'd7);
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (clkRise) begin
            shiftIn <= {shiftIn[6:0], diQ[1]};
        end
    end

    assign frameDone = byteDone &&
        ((rxState == RxLen && shiftIn == '0) ||
         (rxState == RxPayload && payloadCnt + 8'd1 == payloadLen));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxState <= RxType;
            payloadCnt <= '0;
            canSend <= 1'b1;
            msgValid <= 1'b0;
        end else begin
            msgValid <= 1'b0;
            if (rxMsg.credit) begin
                canSend <= 1'b1;
            end
            if (!csOn) begin
                rxState <= RxType;
            end else if (byteDone) begin
                case (rxState)
                    // Zero type bytes are skipped, so a new message can start anywhere
                    RxType: begin
                        if (shiftIn != '0) begin
                            rxState <= RxLen;
                        end
                    end
                    RxLen: begin
                        payloadCnt <= '0;
                        rxState <= (shiftIn == '0) ? RxType : RxPayload;
                    end
                    RxPayload: begin
                        payloadCnt <= payloadCnt + 8'd1;
                        if (frameDone) begin
                            rxState <= RxType;
                        end
                    end
                    default: rxState <= RxType;
                endcase
                // Without a credit the message is lost
                if (frameDone && canSend) begin
                    msgValid <= 1'b1;
                    canSend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csOn && byteDone) begin
            case (rxState)
                RxType: msgType <= shiftIn;
                RxLen: payloadLen <= shiftIn;
                RxPayload: begin
                    if (payloadCnt < MsgMaxPayloadLen) begin
                        payload[payloadCnt[IdxW-1:0]] <= shiftIn;
                    end
                end
                default: ;
            endcase
        end
    end

    assign rxMsg.valid = msgValid;
    assign rxMsg.msgType = msgType;
    assign rxMsg.payloadLen = payloadLen;
    assign rxMsg.payload = payload;

    // ==============================
    // Output queue and serialiser
    // ==============================

    // Head byte leaves at the first edge of each 8-edge slot
    assign popByte = csOn && clkRise && slotCnt == 3'd0 && qCount != '0;

    always_ff @(posedge clk) begin
        if (txByte.valid) begin
            queue[wrPtr] <= txByte.data;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            qCount <= '0;
            txCredit <= 1'b0;
        end else begin
            txCredit <= popByte;
            if (txByte.valid) begin
                wrPtr <= (wrPtr == PtrW'(OutQueueDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popByte) begin
                rdPtr <= (rdPtr == PtrW'(OutQueueDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({txByte.valid, popByte})
                2'b10: qCount <= qCount + 1'b1;
                2'b01: qCount <= qCount - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slotCnt <= '0;
            shiftOut <= '0;
        end else if (!csOn) begin
            slotCnt <= '0;
            shiftOut <= '0;
        end else if (clkRise) begin
            slotCnt <= slotCnt + 3'd1;
            if (slotCnt == 3'd0) begin
                // Empty queue sends a zero byte
                shiftOut <= (qCount != '0) ? queue[rdPtr] : '0;
            end else begin
                shiftOut <= {shiftOut[6:0], 1'b0};
            end
        end
    end

    assign debugDo = shiftOut[7];
    assign txByte.credit = txCredit;

endmodule

`default_nettype wire

// ==== rtl/msgDispatch.sv ====
`default_nettype none

module msgDispatch #(
    parameter int MsgMaxPayloadLen = dbgPkg::MsgMaxPayloadLen
) (
    input wire clk,
    input wire rstN,
    msgIfc.receiver rxMsg,
    msgIfc.sender fillCmd,
    msgIfc.sender readCmd,
    output logic [3:0] led
);
    typedef enum logic [1:0] {DspIdle, DspFill, DspRead} dspState_t;

    dspState_t state;
    logic canFill;
    logic canRead;
    logic rxCredit;
    logic fillValid;
    logic readValid;
    dbgPkg::byte_t heldType;
    dbgPkg::byte_t heldLen;
    dbgPkg::byte_t [MsgMaxPayloadLen-1:0] heldPayload;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= DspIdle;
            canFill <= 1'b1;
            canRead <= 1'b1;
            rxCredit <= 1'b0;
            fillValid <= 1'b0;
            readValid <= 1'b0;
            led <= '0;
        end else begin
            rxCredit <= 1'b0;
            fillValid <= 1'b0;
            readValid <= 1'b0;
            if (fillCmd.credit) begin
                canFill <= 1'b1;
            end
            if (readCmd.credit) begin
                canRead <= 1'b1;
            end
            case (state)
                DspIdle: begin
                    if (rxMsg.valid) begin
                        case (rxMsg.msgType)
                            dbgPkg::MsgSetLed: begin
                                led <= rxMsg.payload[0][3:0];
                                rxCredit <= 1'b1;
                            end
                            dbgPkg::MsgFillMem: state <= DspFill;
                            dbgPkg::MsgReadMem: state <= DspRead;
                            // Unknown types
                            default: rxCredit <= 1'b1;
                        endcase
                    end
                end
                // Held until the agent is free
                DspFill: begin
                    if (canFill) begin
                        fillValid <= 1'b1;
                        canFill <= 1'b0;
                        rxCredit <= 1'b1;
                        state <= DspIdle;
                    end
                end
                DspRead: begin
                    if (canRead) begin
                        readValid <= 1'b1;
                        canRead <= 1'b0;
                        rxCredit <= 1'b1;
                        state <= DspIdle;
                    end
                end
                default: state <= DspIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DspIdle && rxMsg.valid) begin
            heldType <= rxMsg.msgType;
            heldLen <= rxMsg.payloadLen;
            heldPayload <= rxMsg.payload;
        end
    end

    assign rxMsg.credit = rxCredit;

    assign fillCmd.valid = fillValid;
    assign fillCmd.msgType = heldType;
    assign fillCmd.payloadLen = heldLen;
    assign fillCmd.payload = heldPayload;

    assign readCmd.valid = readValid;
    assign readCmd.msgType = heldType;
    assign readCmd.payloadLen = heldLen;
    assign readCmd.payload = heldPayload;

endmodule

`default_nettype wire

// ==== rtl/memFillAgent.sv ====
`default_nettype none

module memFillAgent (
    input wire clk,
    input wire rstN,
    msgIfc.receiver cmd,
    memIfc.requester mem
);
    typedef enum logic {FillIdle, FillRun} fillState_t;

    fillState_t state;
    dbgPkg::byte_t remaining;
    dbgPkg::memAddr_t addr;
    dbgPkg::memData_t data;
    logic done;

    // Payload is addr, count, seedHi, seedLo
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= FillIdle;
            remaining <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                FillIdle: begin
                    if (cmd.valid) begin
                        remaining <= cmd.payload[1];
                        if (cmd.payload[1] == '0) begin
                            done <= 1'b1;
                        end else begin
                            state <= FillRun;
                        end
                    end
                end
                FillRun: begin
                    if (mem.gnt) begin
                        remaining <= remaining - 8'd1;
                        if (remaining == 8'd1) begin
                            done <= 1'b1;
                            state <= FillIdle;
                        end
                    end
                end
                default: state <= FillIdle;
            endcase
        end
    end

    // Address wraps at 256 on its own
    always_ff @(posedge clk) begin
        if (state == FillIdle && cmd.valid) begin
            addr <= cmd.payload[0];
            data <= {cmd.payload[2], cmd.payload[3]};
        end else if (mem.gnt) begin
            addr <= addr + 1'b1;
            data <= data + 1'b1;
        end
    end

    assign mem.req = (state == FillRun);
    assign mem.write = 1'b1;
    assign mem.addr = addr;
    assign mem.wdata = data;
    assign cmd.credit = done;

endmodule

`default_nettype wire

// ==== rtl/memReadAgent.sv ====
`default_nettype none

module memReadAgent #(
    parameter int OutQueueDepth = dbgPkg::OutQueueDepth
) (
    input wire clk,
    input wire rstN,
    msgIfc.receiver cmd,
    memIfc.requester mem,
    byteIfc.sender txByte
);
    localparam int CreditW = $clog2(OutQueueDepth + 1);

    typedef enum logic [2:0] {RdIdle, RdType, RdLen, RdReq, RdData, RdLow} rdState_t;

    rdState_t state;
    dbgPkg::byte_t remaining;
    dbgPkg::memAddr_t addr;
    dbgPkg::byte_t loByte;
    logic [CreditW-1:0] credits;
    logic push;
    dbgPkg::byte_t pushData;
    logic txValid;
    dbgPkg::byte_t txData;
    logic done;

    // One credit per byte, the low byte rides on the credit kept at the grant
    always_comb begin
        push = 1'b0;
        pushData = loByte;
        case (state)
            RdType: begin
                push = (credits != '0);
                pushData = dbgPkg::MsgReadResp;
            end
            RdLen: begin
                push = (credits != '0);
                pushData = {remaining[6:0], 1'b0};
            end
            RdData: begin
                push = mem.rdataValid;
                pushData = mem.rdata[15:8];
            end
            RdLow: push = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= RdIdle;
            remaining <= '0;
            credits <= CreditW'(OutQueueDepth);
            txValid <= 1'b0;
            done <= 1'b0;
        end else begin
            txValid <= push;
            done <= 1'b0;
            case ({txByte.credit, push})
                2'b10: credits <= credits + 1'b1;
                2'b01: credits <= credits - 1'b1;
                default: ;
            endcase
            case (state)
                RdIdle: begin
                    if (cmd.valid) begin
                        remaining <= cmd.payload[1];
                        state <= RdType;
                    end
                end
                RdType: begin
                    if (push) begin
                        state <= RdLen;
                    end
                end
                RdLen: begin
                    if (push) begin
                        done <= (remaining == '0);
                        state <= (remaining == '0) ? RdIdle : RdReq;
                    end
                end
                RdReq: begin
                    if (mem.gnt) begin
                        state <= RdData;
                    end
                end
                RdData: begin
                    if (mem.rdataValid) begin
                        state <= RdLow;
                    end
                end
                RdLow: begin
                    remaining <= remaining - 8'd1;
                    done <= (remaining == 8'd1);
                    state <= (remaining == 8'd1) ? RdIdle : RdReq;
                end
                default: state <= RdIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        txData <= pushData;
        if (state == RdIdle && cmd.valid) begin
            addr <= cmd.payload[0];
        end else if (mem.gnt) begin
            addr <= addr + 1'b1;
        end
        if (state == RdData && mem.rdataValid) begin
            loByte <= mem.rdata[7:0];
        end
    end

    // Only ask for a word when both of its bytes fit
    assign mem.req = (state == RdReq) && (credits >= CreditW'(2));
    assign mem.write = 1'b0;
    assign mem.addr = addr;
    assign mem.wdata = '0;

    assign txByte.valid = txValid;
    assign txByte.data = txData;
    assign cmd.credit = done;

endmodule

`default_nettype wire

// ==== rtl/memArbiter.sv ====
`default_nettype none

module memArbiter (
    input wire clk,
    input wire rstN,
    memIfc.responder fillPort,
    memIfc.responder readPort
);
    dbgPkg::memData_t mem [256];
    logic readFirst;
    logic selFill;
    logic selRead;
    logic write;
    dbgPkg::memAddr_t addr;
    dbgPkg::memData_t wdata;
    dbgPkg::memData_t rdata;
    logic fillRdValid;
    logic readRdValid;

    // Round robin, the port not served last wins a tie
    assign selRead = readPort.req && (!fillPort.req || readFirst);
    assign selFill = fillPort.req && !selRead;

    assign write = selRead ? readPort.write : fillPort.write;
    assign addr = selRead ? readPort.addr : fillPort.addr;
    assign wdata = selRead ? readPort.wdata : fillPort.wdata;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= '0;
            end
            readFirst <= 1'b0;
            fillRdValid <= 1'b0;
            readRdValid <= 1'b0;
        end else begin
            if ((selFill || selRead) && write) begin
                mem[addr] <= wdata;
            end
            if (selFill) begin
                readFirst <= 1'b1;
            end else if (selRead) begin
                readFirst <= 1'b0;
            end
            fillRdValid <= selFill && !fillPort.write;
            readRdValid <= selRead && !readPort.write;
        end
    end

    // Read data is shared, rdataValid tells which port it is for
    always_ff @(posedge clk) begin
        if ((selFill || selRead) && !write) begin
            rdata <= mem[addr];
        end
    end

    assign fillPort.gnt = selFill;
    assign readPort.gnt = selRead;
    assign fillPort.rdataValid = fillRdValid;
    assign readPort.rdataValid = readRdValid;
    assign fillPort.rdata = rdata;
    assign readPort.rdata = rdata;

endmodule

`default_nettype wire

// ==== rtl/debugLinkTop.sv ====
`default_nettype none

module debugLinkTop #(
    parameter int MsgMaxPayloadLen = dbgPkg::MsgMaxPayloadLen,
    parameter int OutQueueDepth = dbgPkg::OutQueueDepth
) (
    input wire clk,
    input wire rstN,
    input wire debugClk,
    input wire debugCs,
    input wire debugDi,
    output wire debugDo,
    output wire [3:0] led
);
    // ==============================
    // Links between blocks
    // ==============================

    msgIfc #(.MsgMaxPayloadLen(MsgMaxPayloadLen)) rxMsg ();
    msgIfc #(.MsgMaxPayloadLen(MsgMaxPayloadLen)) fillCmd ();
    msgIfc #(.MsgMaxPayloadLen(MsgMaxPayloadLen)) readCmd ();
    byteIfc #(.OutQueueDepth(OutQueueDepth)) txByte ();
    memIfc fillPort ();
    memIfc readPort ();

    // ==============================
    // Blocks
    // ==============================

    serialLink #(
        .MsgMaxPayloadLen(MsgMaxPayloadLen),
        .OutQueueDepth(OutQueueDepth)
    ) u_serialLink (
        .clk(clk),
        .rstN(rstN),
        .debugClk(debugClk),
        .debugCs(debugCs),
        .debugDi(debugDi),
        .debugDo(debugDo),
        .rxMsg(rxMsg),
        .txByte(txByte)
    );

    msgDispatch #(
        .MsgMaxPayloadLen(MsgMaxPayloadLen)
    ) u_msgDispatch (
        .clk(clk),
        .rstN(rstN),
        .rxMsg(rxMsg),
        .fillCmd(fillCmd),
        .readCmd(readCmd),
        .led(led)
    );

    memFillAgent u_memFillAgent (
        .clk(clk),
        .rstN(rstN),
        .cmd(fillCmd),
        .mem(fillPort)
    );

    memReadAgent #(
        .OutQueueDepth(OutQueueDepth)
    ) u_memReadAgent (
        .clk(clk),
        .rstN(rstN),
        .cmd(readCmd),
        .mem(readPort),
        .txByte(txByte)
    );

    memArbiter u_memArbiter (
        .clk(clk),
        .rstN(rstN),
        .fillPort(fillPort),
        .readPort(readPort)
    );

endmodule

`default_nettype wire

// ==== tb/debugLinkTop_chk.sv ====
`default_nettype none

module debugLinkTop_chk #(
    parameter int OutQueueDepth = dbgPkg::OutQueueDepth
) (
    input wire clk,
    input wire rstN,
    input wire fillReq,
    input wire fillGnt,
    input wire readReq,
    input wire readGnt,
    input wire [$clog2(OutQueueDepth + 1)-1:0] credits
);
    // At most one memory port served per cycle
    gntOneHot: assert property (@(posedge clk) disable iff (!rstN)
        !(fillGnt && readGnt))
        else $error("Memory grant given to both ports in the same cycle");

    // Credits come back only for bytes that were pushed
    creditLimit: assert property (@(posedge clk) disable iff (!rstN)
        credits <= OutQueueDepth)
        else $error("Read agent holds more byte credits than queue slots");

    // A request stays up until it is granted
    fillReqHeld: assert property (@(posedge clk) disable iff (!rstN)
        fillReq && !fillGnt |=> fillReq)
        else $error("Fill request withdrawn before its grant");

    readReqHeld: assert property (@(posedge clk) disable iff (!rstN)
        readReq && !readGnt |=> readReq)
        else $error("Read request withdrawn before its grant");

    // The port served last gives way to a waiting one
    fillAfterRead: assert property (@(posedge clk) disable iff (!rstN)
        readGnt && fillReq |=> fillGnt)
        else $error("Fill port passed over after a read grant");

    readAfterFill: assert property (@(posedge clk) disable iff (!rstN)
        fillGnt && readReq |=> readGnt)
        else $error("Read port passed over after a fill grant");

endmodule

bind debugLinkTop debugLinkTop_chk #(
    .OutQueueDepth(OutQueueDepth)
) u_debugLinkTop_chk (
    .clk(clk),
    .rstN(rstN),
    .fillReq(fillPort.req),
    .fillGnt(fillPort.gnt),
    .readReq(readPort.req),
    .readGnt(readPort.gnt),
    .credits(u_memReadAgent.credits)
);

`default_nettype wire

// ==== tb/debugLinkTop_tb.sv ====
`default_nettype none

module debugLinkTop_tb;
    localparam int MaxRows = 12;
    localparam int MaxBytes = 24;
    localparam int ClkPerBit = 8;
    localparam int ColType = 0;
    localparam int ColLen = 1;
    localparam int ColData = 2;

    logic clk;
    logic rstN;
    logic debugClk;
    logic debugCs;
    logic debugDi;
    wire debugDo;
    wire [3:0] led;

    // Table rows, message bytes in and response bytes out
    logic [7:0] rowMsg [MaxRows][MaxBytes];
    logic [7:0] rowResp [MaxRows][MaxBytes];
    int rowMsgLen [MaxRows];
    int rowRespLen [MaxRows];
    logic [3:0] rowLed [MaxRows];
    int rowCount;

    // Software view of the scratch memory and the LEDs
    logic [15:0] memModel [256];
    logic [3:0] ledModel;

    // Response framing on debugDo
    logic [7:0] rxQ [$];
    logic [7:0] outShift;
    int outBits;
    int colState;
    int colLeft;

    int errors;
    int seed;
    int cycles;
    int cycleLimit;

    debugLinkTop u_debugLinkTop (
        .clk(clk),
        .rstN(rstN),
        .debugClk(debugClk),
        .debugCs(debugCs),
        .debugDi(debugDi),
        .debugDo(debugDo),
        .led(led)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout, no complete response after %0d clock cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ==============================
    // Table building
    // ==============================

    task automatic startRow();
        rowMsgLen[rowCount] = 0;
        rowRespLen[rowCount] = 0;
    endtask

    task automatic finishRow();
        rowLed[rowCount] = ledModel;
        rowCount = rowCount + 1;
    endtask

    task automatic appendMsg(input logic [7:0] b);
        rowMsg[rowCount][rowMsgLen[rowCount]] = b;
        rowMsgLen[rowCount] = rowMsgLen[rowCount] + 1;
    endtask

    task automatic appendResp(input logic [7:0] b);
        rowResp[rowCount][rowRespLen[rowCount]] = b;
        rowRespLen[rowCount] = rowRespLen[rowCount] + 1;
    endtask

    // LEDs take the low nibble of payload byte 0
    task automatic addSetLed(input logic [7:0] len, input logic [7:0] first);
        appendMsg(dbgPkg::MsgSetLed);
        appendMsg(len);
        appendMsg(first);
        for (int i = 1; i < len; i++) begin
            appendMsg(8'hA0 + 8'(i));
        end
        ledModel = first[3:0];
    endtask

    task automatic addFill(input logic [7:0] addr, input logic [7:0] count,
                           input logic [15:0] seedWord);
        appendMsg(dbgPkg::MsgFillMem);
        appendMsg(8'h04);
        appendMsg(addr);
        appendMsg(count);
        appendMsg(seedWord[15:8]);
        appendMsg(seedWord[7:0]);
        for (int i = 0; i < count; i++) begin
            memModel[8'(addr + i)] = seedWord + 16'(i);
        end
    endtask

    // Response is type, 2*count, then each word high byte first
    task automatic addRead(input logic [7:0] addr, input logic [7:0] count);
        logic [15:0] word;
        appendMsg(dbgPkg::MsgReadMem);
        appendMsg(8'h02);
        appendMsg(addr);
        appendMsg(count);
        appendResp(8'h83);
        appendResp(8'(2 * count));
        for (int i = 0; i < count; i++) begin
            word = memModel[8'(addr + i)];
            appendResp(word[15:8]);
            appendResp(word[7:0]);
        end
    endtask

    task automatic buildTable();
        startRow();
        addSetLed(8'd1, 8'h0A);
        finishRow();
        startRow();
        addFill(8'h10, 8'd4, 16'h1234);
        finishRow();
        startRow();
        addRead(8'h10, 8'd4);
        finishRow();
        startRow();
        addFill(8'h40, 8'd8, 16'hBEEF);
        finishRow();
        // Longer than the output queue
        startRow();
        addRead(8'h40, 8'd8);
        finishRow();
        // Read of an untouched range while a large fill runs
        startRow();
        addRead(8'h80, 8'd8);
        addFill(8'h90, 8'h70, 16'h0F00);
        finishRow();
        startRow();
        addRead(8'hFC, 8'd6);
        finishRow();
        // Payload longer than the kept length
        startRow();
        addSetLed(8'd7, 8'h05);
        finishRow();
        startRow();
        addSetLed(8'd1, 8'h0C);
        finishRow();
        startRow();
        addRead(8'h12, 8'd2);
        finishRow();
    endtask

    // ==============================
    // Serial link
    // ==============================

    task automatic frameOutByte(input logic [7:0] b);
        case (colState)
            ColType: begin
                if (b != 8'h00) begin
                    rxQ.push_back(b);
                    colState = ColLen;
                end
            end
            ColLen: begin
                rxQ.push_back(b);
                colLeft = b;
                colState = (b == 8'h00) ? ColType : ColData;
            end
            default: begin
                rxQ.push_back(b);
                colLeft = colLeft - 1;
                if (colLeft == 0) begin
                    colState = ColType;
                end
            end
        endcase
    endtask

    task automatic shiftBit(input logic din);
        debugDi = din;
        debugClk = 1'b1;
        repeat (ClkPerBit / 2) @(posedge clk);
        #1;
        // debugDo has settled for this edge
        outShift = {outShift[6:0], debugDo};
        outBits = outBits + 1;
        if (outBits == 8) begin
            outBits = 0;
            frameOutByte(outShift);
        end
        debugClk = 1'b0;
        repeat (ClkPerBit / 2) @(posedge clk);
        #1;
    endtask

    task automatic sendByte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            shiftBit(b[i]);
        end
    endtask

    task automatic compareValue(input logic [15:0] actual, input logic [15:0] expected,
                                input string what);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
        end
    endtask

    task automatic runRow(input int r);
        logic [7:0] got;
        for (int i = 0; i < rowMsgLen[r]; i++) begin
            sendByte(rowMsg[r][i]);
        end
        // Keep clocking nops until the whole response is in
        while (rxQ.size() < rowRespLen[r]) begin
            sendByte(8'h00);
        end
        sendByte(8'h00);
        for (int i = 0; i < rowRespLen[r]; i++) begin
            got = rxQ.pop_front();
            compareValue(16'(got), 16'(rowResp[r][i]),
                         $sformatf("row %0d response byte %0d", r, i));
        end
        compareValue(16'(led), 16'(rowLed[r]), $sformatf("row %0d led", r));
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int tableBytes;
        int nops;
        clk = 1'b0;
        rstN = 1'b0;
        debugClk = 1'b0;
        debugCs = 1'b0;
        debugDi = 1'b0;
        errors = 0;
        seed = 41;
        cycles = 0;
        outShift = '0;
        outBits = 0;
        colState = ColType;
        colLeft = 0;
        rowCount = 0;
        ledModel = '0;
        for (int a = 0; a < 256; a++) begin
            memModel[a] = '0;
        end
        buildTable();
        tableBytes = 0;
        for (int r = 0; r < rowCount; r++) begin
            tableBytes = tableBytes + rowMsgLen[r] + rowRespLen[r];
        end
        cycleLimit = tableBytes * 200 * ClkPerBit;

        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        debugCs = 1'b1;
        repeat (ClkPerBit) @(posedge clk);
        #1;

        for (int r = 0; r < rowCount; r++) begin
            nops = $random(seed) & 3;
            repeat (nops) sendByte(8'h00);
            runRow(r);
        end
        repeat (4) sendByte(8'h00);
        compareValue(16'(rxQ.size()), 16'h0, "count of stray response bytes");

        $display("Finished %0d rows with %0d errors", rowCount, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== debugLink.f ====
rtl/dbgPkg.sv
rtl/dbgIfc.sv
rtl/serialLink.sv
rtl/msgDispatch.sv
rtl/memFillAgent.sv
rtl/memReadAgent.sv
rtl/memArbiter.sv
rtl/debugLinkTop.sv
tb/debugLinkTop_chk.sv
tb/debugLinkTop_tb.sv

// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/VdebugLinkTop_tb
	./obj_dir/VdebugLinkTop_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

obj_dir/VdebugLinkTop_tb: debugLink.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module debugLinkTop_tb \
		-f debugLink.f -Mdir obj_dir -o VdebugLinkTop_tb

clean:
	rm -rf obj_dir sim.log
